/* mem_config.svh */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// cache line and burst beat geometry
`define MEM_LINE_W          256
`define MEM_BEAT_W          64
`define MEM_BEATS           4

// byte address, bits 4:0 select a byte inside a line
`define MEM_ADDR_W          32

// lines held by the burst memory model
`define MEM_DEPTH_LINES     64

// cycles from an accepted read command to the first read beat
`define MEM_RD_LATENCY      3

// ready drops for REFRESH_LEN cycles out of every REFRESH_PERIOD
`define MEM_REFRESH_PERIOD  23
`define MEM_REFRESH_LEN     2

`endif

/* mem_pkg.sv */
package mem_pkg;

    // owner of the single line transfer in flight
    typedef enum logic [1:0]
    {
        ARB_IDLE = 2'b00,
        ARB_INST = 2'b01,
        ARB_DATA = 2'b10
    } arb_state_e;

    // opcode on the line request and on the burst bus
    typedef enum logic [1:0]
    {
        BURST_NOP   = 2'b00,
        BURST_READ  = 2'b01,
        BURST_WRITE = 2'b10
    } burst_op_e;

endpackage : mem_pkg

/* cache_arbiter.sv */
`include "mem_config.svh"

module cache_arbiter
    import mem_pkg::*;
    (
        input  logic                   clk,
        input  logic                   rst,

        // instruction port, read only
        input  logic [`MEM_ADDR_W-1:0] i_inst_addr,
        input  logic                   i_inst_read,
        output logic [`MEM_LINE_W-1:0] o_inst_rdata,
        output logic                   o_inst_resp,

        // data port
        input  logic [`MEM_ADDR_W-1:0] i_data_addr,
        input  logic                   i_data_read,
        input  logic                   i_data_write,
        input  logic [`MEM_LINE_W-1:0] i_data_wdata,
        output logic [`MEM_LINE_W-1:0] o_data_rdata,
        output logic                   o_data_resp,

        // line request towards the burst adapter
        output logic [`MEM_ADDR_W-1:0] o_line_addr,
        output burst_op_e              o_line_op,
        output logic [`MEM_LINE_W-1:0] o_line_wdata,
        input  logic                   i_line_done,
        input  logic [`MEM_LINE_W-1:0] i_line_rdata
    );

    localparam int OFF_W = $clog2(`MEM_LINE_W / 8);

    arb_state_e state;

    logic                   inst_req;
    logic                   data_req;
    logic                   contested;
    logic                   grant_data;
    logic                   done_q;
    logic                   tie_data_q;

    logic [`MEM_ADDR_W-1:0] addr_q;
    burst_op_e              op_q;
    logic [`MEM_LINE_W-1:0] wdata_q;

    assign inst_req  = i_inst_read;
    assign data_req  = i_data_read | i_data_write;
    assign contested = inst_req & data_req;

    // a tie right after a transfer goes to the port that lost the last tie
    always_comb
    begin
        if (contested)
        begin
            grant_data = done_q ? ~tie_data_q : 1'b1;
        end
        else
        begin
            grant_data = data_req;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= ARB_IDLE;
            done_q     <= 1'b0;
            tie_data_q <= 1'b0;
        end
        else
        begin
            done_q <= i_line_done;
            case (state)
                ARB_IDLE:
                begin
                    if (grant_data)
                    begin
                        state <= ARB_DATA;
                    end
                    else if (inst_req)
                    begin
                        state <= ARB_INST;
                    end
                    if (contested)
                    begin
                        tie_data_q <= grant_data;
                    end
                end
                default:
                begin
                    if (i_line_done)
                    begin
                        state <= ARB_IDLE;
                    end
                end
            endcase
        end
    end

    // winner's request, held for the whole transfer
    always_ff @(posedge clk)
    begin
        if (state == ARB_IDLE)
        begin
            if (grant_data)
            begin
                addr_q  <= {i_data_addr[`MEM_ADDR_W-1:OFF_W], OFF_W'(0)};
                op_q    <= i_data_write ? BURST_WRITE : BURST_READ;
                wdata_q <= i_data_wdata;
            end
            else if (inst_req)
            begin
                addr_q <= {i_inst_addr[`MEM_ADDR_W-1:OFF_W], OFF_W'(0)};
                op_q   <= BURST_READ;
            end
        end
    end

    assign o_line_addr  = addr_q;
    assign o_line_op    = (state == ARB_IDLE) ? BURST_NOP : op_q;
    assign o_line_wdata = wdata_q;

    // response goes only to the owner
    assign o_inst_resp  = (state == ARB_INST) & i_line_done;
    assign o_data_resp  = (state == ARB_DATA) & i_line_done;
    assign o_inst_rdata = o_inst_resp ? i_line_rdata : '0;
    assign o_data_rdata = o_data_resp ? i_line_rdata : '0;

    // a done pulse with no owner would be lost
    a_done_owned: assert property (@(posedge clk) disable iff (rst)
        i_line_done |-> (state != ARB_IDLE));

    // the owning port keeps its request up until its response
    a_owner_holds: assert property (@(posedge clk) disable iff (rst)
        (state != ARB_INST || inst_req) && (state != ARB_DATA || data_req));

endmodule : cache_arbiter

/* burst_adapter.sv */
`include "mem_config.svh"

module burst_adapter
    import mem_pkg::*;
    (
        input  logic                   clk,
        input  logic                   rst,

        // line request from the arbiter
        input  logic [`MEM_ADDR_W-1:0] i_line_addr,
        input  burst_op_e              i_line_op,
        input  logic [`MEM_LINE_W-1:0] i_line_wdata,
        output logic                   o_line_done,
        output logic [`MEM_LINE_W-1:0] o_line_rdata,

        // burst memory bus
        output burst_op_e              o_bm_op,
        output logic [`MEM_ADDR_W-1:0] o_bm_addr,
        output logic [`MEM_BEAT_W-1:0] o_bm_wdata,
        input  logic                   i_bm_ready,
        input  logic [`MEM_BEAT_W-1:0] i_bm_rdata,
        input  logic                   i_bm_rvalid
    );

    localparam int BEATS = `MEM_BEATS;
    localparam int CNT_W = $clog2(BEATS);

    typedef enum logic [1:0]
    {
        SEQ_IDLE  = 2'b00,
        SEQ_WRITE = 2'b01,
        SEQ_RCMD  = 2'b10,
        SEQ_RDATA = 2'b11
    } seq_state_e;

    seq_state_e             seq;
    logic [CNT_W-1:0]       beat_cnt;
    logic                   busy;
    logic                   done_q;
    logic                   start;
    logic                   last_beat;
    logic [`MEM_LINE_W-1:0] rdata_q;

    // busy stays set until the arbiter lets go of the finished request
    assign start     = (seq == SEQ_IDLE) && !busy && (i_line_op != BURST_NOP);
    assign last_beat = (beat_cnt == CNT_W'(BEATS - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            seq      <= SEQ_IDLE;
            beat_cnt <= '0;
            busy     <= 1'b0;
            done_q   <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (seq)
                SEQ_IDLE:
                begin
                    if (start)
                    begin
                        busy     <= 1'b1;
                        beat_cnt <= '0;
                        seq      <= (i_line_op == BURST_WRITE) ? SEQ_WRITE : SEQ_RCMD;
                    end
                    else if (i_line_op == BURST_NOP)
                    begin
                        busy <= 1'b0;
                    end
                end
                SEQ_WRITE:
                begin
                    if (i_bm_ready)
                    begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat)
                        begin
                            seq    <= SEQ_IDLE;
                            done_q <= 1'b1;
                        end
                    end
                end
                SEQ_RCMD:
                begin
                    if (i_bm_ready)
                    begin
                        seq <= SEQ_RDATA;
                    end
                end
                SEQ_RDATA:
                begin
                    if (i_bm_rvalid)
                    begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat)
                        begin
                            seq    <= SEQ_IDLE;
                            done_q <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // lowest beat arrives first and ends up in the low bits
    always_ff @(posedge clk)
    begin
        if (seq == SEQ_RDATA && i_bm_rvalid)
        begin
            rdata_q <= {i_bm_rdata, rdata_q[`MEM_LINE_W-1:`MEM_BEAT_W]};
        end
    end

    always_comb
    begin
        case (seq)
            SEQ_WRITE: o_bm_op = BURST_WRITE;
            SEQ_RCMD:  o_bm_op = BURST_READ;
            default:   o_bm_op = BURST_NOP;
        endcase
    end

    assign o_bm_addr    = i_line_addr;
    assign o_bm_wdata   = i_line_wdata[beat_cnt * `MEM_BEAT_W +: `MEM_BEAT_W];
    assign o_line_done  = done_q;
    assign o_line_rdata = rdata_q;

    a_rvalid_expected: assert property (@(posedge clk) disable iff (rst)
        i_bm_rvalid |-> (seq == SEQ_RDATA));

endmodule : burst_adapter

/* burst_mem.sv */
`include "mem_config.svh"

module burst_mem
    import mem_pkg::*;
    (
        input  logic                   clk,
        input  logic                   rst,
        input  burst_op_e              i_bm_op,
        input  logic [`MEM_ADDR_W-1:0] i_bm_addr,
        input  logic [`MEM_BEAT_W-1:0] i_bm_wdata,
        output logic                   o_bm_ready,
        output logic [`MEM_BEAT_W-1:0] o_bm_rdata,
        output logic                   o_bm_rvalid
    );

    localparam int BEATS = `MEM_BEATS;
    localparam int CNT_W = $clog2(BEATS);
    localparam int OFF_W = $clog2(`MEM_LINE_W / 8);
    localparam int IDX_W = $clog2(`MEM_DEPTH_LINES);
    localparam int LAT_W = $clog2(`MEM_RD_LATENCY + 1);
    localparam int REF_W = $clog2(`MEM_REFRESH_PERIOD);

    logic [`MEM_BEAT_W-1:0] mem [`MEM_DEPTH_LINES * BEATS];

    logic [IDX_W-1:0] addr_idx;
    logic [IDX_W-1:0] wr_line;
    logic [CNT_W-1:0] wr_cnt;
    logic [IDX_W-1:0] rd_line;
    logic [CNT_W-1:0] rd_beat;
    logic [LAT_W-1:0] lat_cnt;
    logic             rd_active;
    logic [REF_W-1:0] ref_cnt;
    logic             wr_accept;
    logic             rd_accept;

    assign addr_idx   = i_bm_addr[OFF_W +: IDX_W];
    assign o_bm_ready = (ref_cnt < REF_W'(`MEM_REFRESH_PERIOD - `MEM_REFRESH_LEN));
    assign wr_accept  = (i_bm_op == BURST_WRITE) && o_bm_ready;
    assign rd_accept  = (i_bm_op == BURST_READ) && o_bm_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ref_cnt <= '0;
        end
        else if (ref_cnt == REF_W'(`MEM_REFRESH_PERIOD - 1))
        begin
            ref_cnt <= '0;
        end
        else
        begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

    // only the first write beat carries an address
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_cnt <= '0;
        end
        else if (wr_accept)
        begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_accept)
        begin
            if (wr_cnt == '0)
            begin
                wr_line                 <= addr_idx;
                mem[{addr_idx, wr_cnt}] <= i_bm_wdata;
            end
            else
            begin
                mem[{wr_line, wr_cnt}] <= i_bm_wdata;
            end
        end
    end

    // read stream, first beat RD_LATENCY cycles after the command
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_active   <= 1'b0;
            o_bm_rvalid <= 1'b0;
        end
        else
        begin
            o_bm_rvalid <= 1'b0;
            if (rd_accept)
            begin
                rd_active <= 1'b1;
                rd_line   <= addr_idx;
                rd_beat   <= '0;
                lat_cnt   <= LAT_W'(`MEM_RD_LATENCY - 2);
            end
            else if (rd_active)
            begin
                if (lat_cnt != '0)
                begin
                    lat_cnt <= lat_cnt - 1'b1;
                end
                else
                begin
                    o_bm_rvalid <= 1'b1;
                    o_bm_rdata  <= mem[{rd_line, rd_beat}];
                    rd_beat     <= rd_beat + 1'b1;
                    if (rd_beat == CNT_W'(BEATS - 1))
                    begin
                        rd_active <= 1'b0;
                    end
                end
            end
        end
    end

    a_no_beat_during_read: assert property (@(posedge clk) disable iff (rst)
        (i_bm_op != BURST_NOP) |-> (!rd_active && !o_bm_rvalid));

endmodule : burst_mem

/* mem_subsystem_top.sv */
`include "mem_config.svh"

module mem_subsystem_top
    import mem_pkg::*;
    (
        input  logic                   clk,
        input  logic                   rst,

        input  logic [`MEM_ADDR_W-1:0] i_inst_addr,
        input  logic                   i_inst_read,
        output logic [`MEM_LINE_W-1:0] o_inst_rdata,
        output logic                   o_inst_resp,

        input  logic [`MEM_ADDR_W-1:0] i_data_addr,
        input  logic                   i_data_read,
        input  logic                   i_data_write,
        input  logic [`MEM_LINE_W-1:0] i_data_wdata,
        output logic [`MEM_LINE_W-1:0] o_data_rdata,
        output logic                   o_data_resp
    );

    // arbiter to adapter
    logic [`MEM_ADDR_W-1:0] line_addr;
    burst_op_e              line_op;
    logic [`MEM_LINE_W-1:0] line_wdata;
    logic                   line_done;
    logic [`MEM_LINE_W-1:0] line_rdata;

    // adapter to memory
    burst_op_e              bm_op;
    logic [`MEM_ADDR_W-1:0] bm_addr;
    logic [`MEM_BEAT_W-1:0] bm_wdata;
    logic                   bm_ready;
    logic [`MEM_BEAT_W-1:0] bm_rdata;
    logic                   bm_rvalid;

    cache_arbiter i_arbiter
    (
        .clk          (clk),
        .rst          (rst),
        .i_inst_addr  (i_inst_addr),
        .i_inst_read  (i_inst_read),
        .o_inst_rdata (o_inst_rdata),
        .o_inst_resp  (o_inst_resp),
        .i_data_addr  (i_data_addr),
        .i_data_read  (i_data_read),
        .i_data_write (i_data_write),
        .i_data_wdata (i_data_wdata),
        .o_data_rdata (o_data_rdata),
        .o_data_resp  (o_data_resp),
        .o_line_addr  (line_addr),
        .o_line_op    (line_op),
        .o_line_wdata (line_wdata),
        .i_line_done  (line_done),
        .i_line_rdata (line_rdata)
    );

    burst_adapter i_adapter
    (
        .clk          (clk),
        .rst          (rst),
        .i_line_addr  (line_addr),
        .i_line_op    (line_op),
        .i_line_wdata (line_wdata),
        .o_line_done  (line_done),
        .o_line_rdata (line_rdata),
        .o_bm_op      (bm_op),
        .o_bm_addr    (bm_addr),
        .o_bm_wdata   (bm_wdata),
        .i_bm_ready   (bm_ready),
        .i_bm_rdata   (bm_rdata),
        .i_bm_rvalid  (bm_rvalid)
    );

    burst_mem i_mem
    (
        .clk         (clk),
        .rst         (rst),
        .i_bm_op     (bm_op),
        .i_bm_addr   (bm_addr),
        .i_bm_wdata  (bm_wdata),
        .o_bm_ready  (bm_ready),
        .o_bm_rdata  (bm_rdata),
        .o_bm_rvalid (bm_rvalid)
    );

endmodule : mem_subsystem_top

/* tb_mem_subsystem.sv */
`include "mem_config.svh"

module tb_mem_subsystem
    import mem_pkg::*;
    ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LINE_W    = `MEM_LINE_W;
    localparam int ADDR_W    = `MEM_ADDR_W;
    localparam int DEPTH     = `MEM_DEPTH_LINES;
    localparam int OFF_W     = $clog2(`MEM_LINE_W / 8);
    localparam int TIMEOUT   = 500;
    localparam int LONG_ROWS = 28;

    typedef enum logic [1:0]
    {
        PORT_INST = 2'b00,
        PORT_DATA = 2'b01,
        PORT_BOTH = 2'b10
    } port_e;

    // one stimulus row, exp is the line a read of this address must return
    typedef struct packed
    {
        int                test;
        port_e             port;
        burst_op_e         op;
        logic [ADDR_W-1:0] addr;
        bit                fresh;
        logic [LINE_W-1:0] wdata;
        logic [LINE_W-1:0] exp;
    } row_t;

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] inst_addr;
    logic              inst_read;
    logic [LINE_W-1:0] inst_rdata;
    logic              inst_resp;
    logic [ADDR_W-1:0] data_addr;
    logic              data_read;
    logic              data_write;
    logic [LINE_W-1:0] data_wdata;
    logic [LINE_W-1:0] data_rdata;
    logic              data_resp;

    row_t              rows[$];
    logic [LINE_W-1:0] ref_mem [DEPTH];
    bit                ref_written [DEPTH];
    logic [15:0]       lfsr_state;
    logic [LINE_W-1:0] inst_seen;
    logic [LINE_W-1:0] data_seen;
    int                checks;
    int                errors;
    int                cur_test;
    int                test_checks0;
    int                test_errors0;
    bit                abort;

    mem_subsystem_top i_dut
    (
        .clk          (clk),
        .rst          (rst),
        .i_inst_addr  (inst_addr),
        .i_inst_read  (inst_read),
        .o_inst_rdata (inst_rdata),
        .o_inst_resp  (inst_resp),
        .i_data_addr  (data_addr),
        .i_data_read  (data_read),
        .i_data_write (data_write),
        .i_data_wdata (data_wdata),
        .o_data_rdata (data_rdata),
        .o_data_resp  (data_resp)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            v[k] = rand_bit();
        end
        return v;
    endfunction

    function automatic logic [LINE_W-1:0] rand_line();
        logic [LINE_W-1:0] v;
        for (int k = 0; k < LINE_W; k++)
        begin
            v[k] = rand_bit();
        end
        return v;
    endfunction

    function automatic logic [LINE_W-1:0] pattern_line(input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] v;
        for (int k = 0; k < LINE_W / 32; k++)
        begin
            v[k * 32 +: 32] = addr ^ (32'h9e37_79b9 * (k + 1));
        end
        return v;
    endfunction

    // bits 4:0 select a byte inside the line and play no part
    function automatic int line_of(input logic [ADDR_W-1:0] addr);
        return int'((addr >> OFF_W) % DEPTH);
    endfunction

    function automatic string test_name(input int n);
        case (n)
            1:       return "quiet during and after reset";
            2:       return "data write and read back";
            3:       return "instruction read of written lines";
            4:       return "data wins a tie from idle";
            5:       return "instruction wins the next tie";
            default: return "long run across refresh stalls";
        endcase
    endfunction

    task add_row(input int test, input port_e port, input burst_op_e op,
                 input logic [ADDR_W-1:0] addr, input bit fresh);
        row_t r;
        int   idx;
        idx     = line_of(addr);
        r.test  = test;
        r.port  = port;
        r.op    = op;
        r.addr  = addr;
        r.fresh = fresh;
        r.wdata = '0;
        if (op == BURST_WRITE)
        begin
            if (fresh)
            begin
                r.wdata = rand_line();
            end
            else
            begin
                r.wdata = pattern_line(addr);
            end
            ref_mem[idx]     = r.wdata;
            ref_written[idx] = 1'b1;
        end
        r.exp = ref_mem[idx];
        rows.push_back(r);
    endtask

    task build_table();
        int                line;
        logic [ADDR_W-1:0] addr;
        logic [1:0]        pick;
        for (int k = 0; k < DEPTH; k++)
        begin
            ref_written[k] = 1'b0;
        end
        add_row(2, PORT_DATA, BURST_WRITE, 32'h0000_00a0, 1'b1);
        add_row(2, PORT_DATA, BURST_READ,  32'h0000_00a0, 1'b0);
        add_row(2, PORT_DATA, BURST_WRITE, 32'h0000_0120, 1'b0);
        add_row(2, PORT_DATA, BURST_READ,  32'h0000_0120, 1'b0);
        add_row(2, PORT_DATA, BURST_WRITE, 32'h0000_07e0, 1'b1);
        add_row(2, PORT_DATA, BURST_READ,  32'h0000_07e0, 1'b0);
        add_row(3, PORT_INST, BURST_READ,  32'h0000_00a0, 1'b0);
        add_row(3, PORT_INST, BURST_READ,  32'h0000_00b3, 1'b0);
        add_row(3, PORT_INST, BURST_READ,  32'h0000_013f, 1'b0);
        add_row(3, PORT_DATA, BURST_READ,  32'h0000_07fc, 1'b0);
        add_row(4, PORT_BOTH, BURST_WRITE, 32'h0000_0240, 1'b1);
        // lines 32 to 39, first touch of a line is always a write
        for (int k = 0; k < LONG_ROWS; k++)
        begin
            line = 32 + int'(rand_bits(3));
            addr = (ADDR_W'(line) << OFF_W) | rand_bits(5);
            pick = 2'(rand_bits(2));
            if (!ref_written[line] || pick == 2'd0)
            begin
                add_row(6, PORT_DATA, BURST_WRITE, addr, 1'b1);
            end
            else if (pick == 2'd1)
            begin
                add_row(6, PORT_DATA, BURST_WRITE, addr, 1'b0);
            end
            else if (pick == 2'd2)
            begin
                add_row(6, PORT_INST, BURST_READ, addr, 1'b0);
            end
            else
            begin
                add_row(6, PORT_DATA, BURST_READ, addr, 1'b0);
            end
        end
    endtask

    task compare_line(input string name, input logic [LINE_W-1:0] exp,
                      input logic [LINE_W-1:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task compare_bit(input string name, input logic exp, input logic act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task require(input bit cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            $display("error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task close_test();
        int n_chk;
        int n_err;
        if (cur_test != 0)
        begin
            n_chk = checks - test_checks0;
            n_err = errors - test_errors0;
            $display("test %0d %s: %s, %0d checks, %0d errors", cur_test,
                     test_name(cur_test), (n_err == 0) ? "ok" : "bad", n_chk, n_err);
        end
    endtask

    task set_test(input int n);
        close_test();
        cur_test     = n;
        test_checks0 = checks;
        test_errors0 = errors;
    endtask

    task set_idle();
        inst_read  = 1'b0;
        data_read  = 1'b0;
        data_write = 1'b0;
    endtask

    // sample at the falling edge, where the responses are settled
    task wait_resp(input bit want_i, input bit want_d, output bit got_i, output bit got_d);
        int n;
        got_i = 1'b0;
        got_d = 1'b0;
        n     = 0;
        if (abort)
        begin
            return;
        end
        while (!got_i && !got_d && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
            got_i     = inst_resp;
            got_d     = data_resp;
            inst_seen = inst_rdata;
            data_seen = data_rdata;
        end
        if (!got_i && !got_d)
        begin
            $display("timeout at %0t: no cache response within %0d cycles", $time, TIMEOUT);
            errors++;
            abort = 1'b1;
        end
        else
        begin
            if (!want_i)
            begin
                require(!got_i, "instruction response without a pending request");
            end
            if (!want_d)
            begin
                require(!got_d, "data response without a pending request");
            end
        end
    endtask

    task quiet_cycle();
        @(negedge clk);
        compare_bit("o_inst_resp", 1'b0, inst_resp);
        compare_bit("o_data_resp", 1'b0, data_resp);
        repeat (2) @(posedge clk);
    endtask

    task apply_reset();
        for (int k = 0; k < 16; k++)
        begin
            @(posedge clk);
            #1;
            if (k == 15)
            begin
                rst = 1'b0;
            end
            @(negedge clk);
            compare_bit("o_inst_resp", 1'b0, inst_resp);
            compare_bit("o_data_resp", 1'b0, data_resp);
        end
        for (int k = 0; k < 16; k++)
        begin
            @(negedge clk);
            compare_bit("o_inst_resp", 1'b0, inst_resp);
            compare_bit("o_data_resp", 1'b0, data_resp);
        end
    endtask

    task run_single(input row_t r);
        bit gi;
        bit gd;
        bit is_inst;
        is_inst = (r.port == PORT_INST);
        @(posedge clk);
        #1;
        if (is_inst)
        begin
            inst_addr = r.addr;
            inst_read = 1'b1;
        end
        else
        begin
            data_addr  = r.addr;
            data_wdata = r.wdata;
            data_read  = (r.op == BURST_READ);
            data_write = (r.op == BURST_WRITE);
        end
        wait_resp(is_inst, !is_inst, gi, gd);
        if (!abort)
        begin
            require(is_inst ? gi : gd, "response arrived on the wrong cache port");
            if (r.op == BURST_READ && is_inst)
            begin
                compare_line("o_inst_rdata", r.exp, inst_seen);
            end
            else if (r.op == BURST_READ)
            begin
                compare_line("o_data_rdata", r.exp, data_seen);
            end
        end
        @(posedge clk);
        #1;
        set_idle();
        quiet_cycle();
    endtask

    // both ports pending, each dropped right after its own response
    task serve_pair(input bit inst_first, input row_t r, input bit data_is_read);
        bit gi;
        bit gd;
        bit inst_pending;
        bit data_pending;
        bit first;
        inst_pending = 1'b1;
        data_pending = 1'b1;
        first        = 1'b1;
        while ((inst_pending || data_pending) && !abort)
        begin
            wait_resp(inst_pending, data_pending, gi, gd);
            if (first && !abort && inst_first)
            begin
                require(gi && !gd, "instruction port was not served ahead of the data port");
            end
            else if (first && !abort)
            begin
                require(gd && !gi, "data port was not served ahead of the instruction port");
            end
            first = 1'b0;
            if (gi)
            begin
                compare_line("o_inst_rdata", r.exp, inst_seen);
            end
            if (gd && data_is_read)
            begin
                compare_line("o_data_rdata", r.exp, data_seen);
            end
            @(posedge clk);
            #1;
            if (gi)
            begin
                inst_read    = 1'b0;
                inst_pending = 1'b0;
            end
            if (gd)
            begin
                data_read    = 1'b0;
                data_write   = 1'b0;
                data_pending = 1'b0;
            end
        end
    endtask

    task run_both(input row_t r);
        @(posedge clk);
        #1;
        inst_addr  = r.addr ^ ADDR_W'('h11);
        inst_read  = 1'b1;
        data_addr  = r.addr;
        data_wdata = r.wdata;
        data_read  = (r.op == BURST_READ);
        data_write = (r.op == BURST_WRITE);
        serve_pair(1'b0, r, r.op == BURST_READ);
        set_test(5);
        // same time step as the drop, so the instruction request never goes low
        inst_addr  = r.addr ^ ADDR_W'('h1f);
        inst_read  = 1'b1;
        data_addr  = r.addr | ADDR_W'('h08);
        data_read  = 1'b1;
        data_write = 1'b0;
        serve_pair(1'b1, r, 1'b1);
        quiet_cycle();
    endtask

    initial
    begin
        rst          = 1'b1;
        inst_addr    = '0;
        inst_read    = 1'b0;
        data_addr    = '0;
        data_read    = 1'b0;
        data_write   = 1'b0;
        data_wdata   = '0;
        lfsr_state   = 16'd26984;
        checks       = 0;
        errors       = 0;
        cur_test     = 0;
        test_checks0 = 0;
        test_errors0 = 0;
        abort        = 1'b0;
        build_table();
        set_test(1);
        apply_reset();
        for (int k = 0; k < rows.size() && !abort; k++)
        begin
            if (rows[k].test != cur_test)
            begin
                set_test(rows[k].test);
            end
            if (rows[k].port == PORT_BOTH)
            begin
                run_both(rows[k]);
            end
            else
            begin
                run_single(rows[k]);
            end
        end
        close_test();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_mem_subsystem

/* verilog.f */
+incdir+.
mem_pkg.sv
cache_arbiter.sv
burst_adapter.sv
burst_mem.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

/* Makefile */
# Verilator build and run for the memory subsystem testbench

TOP       ?= tb_mem_subsystem
SIM_DIR   ?= sim_build
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FILELIST  := verilog.f
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_DIR)/V$(TOP)

$(SIM_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILELIST)

run: compile
	./$(SIM_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(SIM_DIR) $(LOG)
